// File: rtl/procPkg.sv
// ISA widths, memory depths, opcodes and the two-format instruction word union
package procPkg;

   localparam int dataWidth = 16;
   localparam int regAddrWidth = 3;
   localparam int numRegs = 1 << regAddrWidth;
   localparam int imemDepth = 64;
   localparam int dmemDepth = 64;
   localparam int imemAddrWidth = $clog2(imemDepth);
   localparam int dmemAddrWidth = $clog2(dmemDepth);
   localparam int opWidth = 4;
   localparam int immWidth = 6;

   // opcodes, any other code is illegal
   localparam logic [opWidth-1:0] opAdd = 4'h0;
   localparam logic [opWidth-1:0] opSub = 4'h1;
   localparam logic [opWidth-1:0] opAnd = 4'h2;
   localparam logic [opWidth-1:0] opXor = 4'h3;
   localparam logic [opWidth-1:0] opAddi = 4'h4;
   localparam logic [opWidth-1:0] opLd = 4'h5;
   localparam logic [opWidth-1:0] opSt = 4'h6;
   localparam logic [opWidth-1:0] opBeqz = 4'h7;
   localparam logic [opWidth-1:0] opHalt = 4'hf;

   // one 16-bit word seen as register format or immediate format
   // for ST the rd field holds the store data register, BEQZ tests rs
   typedef union packed {
      struct packed {
         logic [opWidth-1:0] opcode;
         logic [regAddrWidth-1:0] rd;
         logic [regAddrWidth-1:0] rs;
         logic [regAddrWidth-1:0] rt;
         logic [2:0] unused;
      } rFmt;
      struct packed {
         logic [opWidth-1:0] opcode;
         logic [regAddrWidth-1:0] rd;
         logic [regAddrWidth-1:0] rs;
         logic [immWidth-1:0] imm6;
      } iFmt;
   } instrT;

   // ADDI r0,r0,0, leaves every register as it was
   localparam logic [dataWidth-1:0] nopWord = {
      opAddi,
      {regAddrWidth{1'b0}},
      {regAddrWidth{1'b0}},
      {immWidth{1'b0}}
   };

   // imm6 is sign extended for ADDI, LD, ST and BEQZ
   // LD/ST address is rs + imm6 modulo dmemDepth
   // taken BEQZ goes to its own pc + 1 + imm6
   // all arithmetic wraps at dataWidth bits

endpackage

// File: rtl/fetch.sv
// fetch stage with PC, loadable instruction memory and the fetch-to-decode register
`timescale 1ns/100ps

module fetch (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  logic halted,
   input  logic stall,
   input  logic redirect,
   input  logic [procPkg::imemAddrWidth-1:0] redirectPc,
   input  logic imemWe,
   input  logic [procPkg::imemAddrWidth-1:0] imemAddr,
   input  logic [procPkg::dataWidth-1:0] imemData,
   output procPkg::instrT instrD,
   output logic [procPkg::imemAddrWidth-1:0] pcD,
   output logic validD
);

   logic [procPkg::imemAddrWidth-1:0] pc;
   procPkg::instrT imem [procPkg::imemDepth];
   procPkg::instrT fetchWord;

   // program load only while the core is stopped
   always_ff @(posedge clk) begin
      if (imemWe && !run) begin
         imem[imemAddr] <= imemData;
      end
   end

   assign fetchWord = imem[pc];

   // pc and the D valid bit
   // halted wins over a redirect so nothing younger than HALT is refetched
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
         validD <= 1'b0;
      end else if (!run) begin
         pc <= '0;
         validD <= 1'b0;
      end else if (halted) begin
         validD <= 1'b0;
      end else if (redirect) begin
         pc <= redirectPc;
         validD <= 1'b0;
      end else if (!stall) begin
         pc <= pc + 1'b1;
         validD <= 1'b1;
      end
   end

   // D slot payload, frozen during a stall
   always_ff @(posedge clk) begin
      if (!stall) begin
         instrD <= fetchWord;
         pcD <= pc;
      end
   end

endmodule

// File: rtl/decode.sv
// decode stage with control decode, register file, load-use stall and the decode-to-execute register
`timescale 1ns/100ps

module decode (
   input  logic clk,
   input  logic rstN,
   input  procPkg::instrT instrD,
   input  logic [procPkg::imemAddrWidth-1:0] pcD,
   input  logic validD,
   input  logic redirect,
   input  logic wbEn,
   input  logic [procPkg::regAddrWidth-1:0] wbReg,
   input  logic [procPkg::dataWidth-1:0] wbData,
   output logic stall,
   output logic validX,
   output logic [procPkg::opWidth-1:0] opX,
   output logic [procPkg::regAddrWidth-1:0] rdX,
   output logic wrEnX,
   output logic memRdX,
   output logic memWrX,
   output logic isBranchX,
   output logic isHaltX,
   output logic illegalX,
   output logic [procPkg::dataWidth-1:0] immX,
   output logic [procPkg::dataWidth-1:0] rsValX,
   output logic [procPkg::dataWidth-1:0] rtValX,
   output logic [procPkg::regAddrWidth-1:0] rsIdxX,
   output logic [procPkg::regAddrWidth-1:0] rtIdxX,
   output logic [procPkg::imemAddrWidth-1:0] pcX
);

   localparam int extBits = procPkg::dataWidth - procPkg::immWidth;

   logic [procPkg::dataWidth-1:0] regs [procPkg::numRegs];
   logic [procPkg::opWidth-1:0] op;
   logic [procPkg::regAddrWidth-1:0] rd;
   logic [procPkg::regAddrWidth-1:0] rs;
   logic [procPkg::regAddrWidth-1:0] rtIdx;
   logic [procPkg::dataWidth-1:0] imm;
   logic [procPkg::dataWidth-1:0] rsVal;
   logic [procPkg::dataWidth-1:0] rtVal;
   logic wrEn;
   logic memRd;
   logic memWr;
   logic isBranch;
   logic isHalt;
   logic illegal;
   logic usesRs;
   logic usesRt;

   // opcode, rd and rt from the register view, rs and imm6 from the immediate view
   assign op = instrD.rFmt.opcode;
   assign rd = instrD.rFmt.rd;
   assign rs = instrD.iFmt.rs;
   assign imm = {{extBits{instrD.iFmt.imm6[procPkg::immWidth-1]}}, instrD.iFmt.imm6};

   always_comb begin
      wrEn = 1'b0;
      memRd = 1'b0;
      memWr = 1'b0;
      isBranch = 1'b0;
      isHalt = 1'b0;
      illegal = 1'b0;
      usesRs = 1'b1;
      usesRt = 1'b0;
      case (op)
         procPkg::opAdd, procPkg::opSub, procPkg::opAnd, procPkg::opXor: begin
            wrEn = 1'b1;
            usesRt = 1'b1;
         end
         procPkg::opAddi: wrEn = 1'b1;
         procPkg::opLd: begin
            wrEn = 1'b1;
            memRd = 1'b1;
         end
         procPkg::opSt: begin
            memWr = 1'b1;
            usesRt = 1'b1;
         end
         procPkg::opBeqz: isBranch = 1'b1;
         procPkg::opHalt: begin
            isHalt = 1'b1;
            usesRs = 1'b0;
         end
         default: begin
            illegal = 1'b1;
            usesRs = 1'b0;
         end
      endcase
   end

   // store data comes from the rd field
   assign rtIdx = memWr ? rd : instrD.rFmt.rt;

   // register file, a same-cycle write shows through to the read
   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   assign rsVal = (wbEn && wbReg == rs) ? wbData : regs[rs];
   assign rtVal = (wbEn && wbReg == rtIdx) ? wbData : regs[rtIdx];

   // load in X feeding the D instruction costs one bubble
   assign stall = validD && validX && memRdX &&
                  ((usesRs && rdX == rs) || (usesRt && rdX == rtIdx));

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validX <= 1'b0;
      end else begin
         validX <= validD && !stall && !redirect;
      end
   end

   always_ff @(posedge clk) begin
      opX <= op;
      rdX <= rd;
      wrEnX <= wrEn;
      memRdX <= memRd;
      memWrX <= memWr;
      isBranchX <= isBranch;
      isHaltX <= isHalt;
      illegalX <= illegal;
      immX <= imm;
      rsValX <= rsVal;
      rtValX <= rtVal;
      rsIdxX <= rs;
      rtIdxX <= rtIdx;
      pcX <= pcD;
   end

endmodule

// File: rtl/execute.sv
// execute stage with operand forwarding, ALU, BEQZ resolution and the execute-to-memory register
`timescale 1ns/100ps

module execute (
   input  logic clk,
   input  logic rstN,
   input  logic validX,
   input  logic [procPkg::opWidth-1:0] opX,
   input  logic [procPkg::regAddrWidth-1:0] rdX,
   input  logic wrEnX,
   input  logic memRdX,
   input  logic memWrX,
   input  logic isBranchX,
   input  logic isHaltX,
   input  logic illegalX,
   input  logic [procPkg::dataWidth-1:0] immX,
   input  logic [procPkg::dataWidth-1:0] rsValX,
   input  logic [procPkg::dataWidth-1:0] rtValX,
   input  logic [procPkg::regAddrWidth-1:0] rsIdxX,
   input  logic [procPkg::regAddrWidth-1:0] rtIdxX,
   input  logic [procPkg::imemAddrWidth-1:0] pcX,
   input  logic fwdMEn,
   input  logic [procPkg::regAddrWidth-1:0] fwdMReg,
   input  logic [procPkg::dataWidth-1:0] fwdMData,
   input  logic fwdWEn,
   input  logic [procPkg::regAddrWidth-1:0] fwdWReg,
   input  logic [procPkg::dataWidth-1:0] fwdWData,
   output logic redirect,
   output logic [procPkg::imemAddrWidth-1:0] redirectPc,
   output logic validM,
   output logic [procPkg::dataWidth-1:0] aluM,
   output logic [procPkg::dataWidth-1:0] storeM,
   output logic [procPkg::regAddrWidth-1:0] rdM,
   output logic wrEnM,
   output logic memRdM,
   output logic memWrM,
   output logic haltM,
   output logic illegalM
);

   logic [procPkg::dataWidth-1:0] opA;
   logic [procPkg::dataWidth-1:0] opB;
   logic [procPkg::dataWidth-1:0] result;

   // youngest producer wins, M before W before the register file value
   function automatic logic [procPkg::dataWidth-1:0] pickOperand(
      input logic [procPkg::regAddrWidth-1:0] idx,
      input logic [procPkg::dataWidth-1:0] regVal
   );
      if (fwdMEn && fwdMReg == idx) begin
         return fwdMData;
      end else if (fwdWEn && fwdWReg == idx) begin
         return fwdWData;
      end
      return regVal;
   endfunction

   always_comb begin
      opA = pickOperand(rsIdxX, rsValX);
      opB = pickOperand(rtIdxX, rtValX);
   end

   // ADDI, LD and ST all take rs + imm
   always_comb begin
      case (opX)
         procPkg::opAdd: result = opA + opB;
         procPkg::opSub: result = opA - opB;
         procPkg::opAnd: result = opA & opB;
         procPkg::opXor: result = opA ^ opB;
         default: result = opA + immX;
      endcase
   end

   // predict not taken, a taken BEQZ redirects while it sits in X
   assign redirect = validX && isBranchX && (opA == '0);
   assign redirectPc = pcX + 1'b1 + immX[procPkg::imemAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validM <= 1'b0;
      end else begin
         validM <= validX;
      end
   end

   always_ff @(posedge clk) begin
      aluM <= result;
      storeM <= opB;
      rdM <= rdX;
      wrEnM <= wrEnX;
      memRdM <= memRdX;
      memWrM <= memWrX;
      haltM <= isHaltX;
      illegalM <= illegalX;
   end

endmodule

// File: rtl/memory.sv
// memory stage with data memory, writeback select, writeback register and sticky halt/err flags
`timescale 1ns/100ps

module memory (
   input  logic clk,
   input  logic rstN,
   input  logic validM,
   input  logic [procPkg::dataWidth-1:0] aluM,
   input  logic [procPkg::dataWidth-1:0] storeM,
   input  logic [procPkg::regAddrWidth-1:0] rdM,
   input  logic wrEnM,
   input  logic memRdM,
   input  logic memWrM,
   input  logic haltM,
   input  logic illegalM,
   output logic fwdMEn,
   output logic [procPkg::regAddrWidth-1:0] fwdMReg,
   output logic [procPkg::dataWidth-1:0] fwdMData,
   output logic fwdWEn,
   output logic [procPkg::regAddrWidth-1:0] fwdWReg,
   output logic [procPkg::dataWidth-1:0] fwdWData,
   output logic wbEn,
   output logic [procPkg::regAddrWidth-1:0] wbReg,
   output logic [procPkg::dataWidth-1:0] wbData,
   output logic halted,
   output logic err
);

   logic [procPkg::dataWidth-1:0] dmem [procPkg::dmemDepth];
   logic [procPkg::dmemAddrWidth-1:0] addr;
   logic [procPkg::dataWidth-1:0] loadData;
   logic [procPkg::dataWidth-1:0] wbValue;
   logic live;
   logic validW;
   logic wrEnW;

   // anything behind a HALT or an illegal word dies here
   assign live = validM && !halted && !err;
   assign addr = aluM[procPkg::dmemAddrWidth-1:0];

   always_ff @(posedge clk) begin
      if (live && memWrM) begin
         dmem[addr] <= storeM;
      end
   end

   assign loadData = dmem[addr];
   assign wbValue = memRdM ? loadData : aluM;

   assign fwdMEn = validM && wrEnM;
   assign fwdMReg = rdM;
   assign fwdMData = wbValue;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         validW <= 1'b0;
         halted <= 1'b0;
         err <= 1'b0;
      end else begin
         validW <= live;
         halted <= halted || (live && haltM);
         err <= err || (live && illegalM);
      end
   end

   always_ff @(posedge clk) begin
      wrEnW <= wrEnM;
      wbReg <= rdM;
      wbData <= wbValue;
   end

   assign wbEn = validW && wrEnW;
   assign fwdWEn = wbEn;
   assign fwdWReg = wbReg;
   assign fwdWData = wbData;

endmodule

// File: rtl/proc.sv
// top level of the five-stage core, wiring fetch, decode, execute and memory
`timescale 1ns/100ps

module proc (
   input  logic clk,
   input  logic rstN,
   input  logic run,
   input  logic imemWe,
   input  logic [procPkg::imemAddrWidth-1:0] imemAddr,
   input  logic [procPkg::dataWidth-1:0] imemData,
   output logic retireValid,
   output logic [procPkg::regAddrWidth-1:0] retireReg,
   output logic [procPkg::dataWidth-1:0] retireData,
   output logic halted,
   output logic err
);

   // fetch to decode
   procPkg::instrT instrD;
   logic [procPkg::imemAddrWidth-1:0] pcD;
   logic validD;
   logic stall;
   logic redirect;
   logic [procPkg::imemAddrWidth-1:0] redirectPc;

   // decode to execute
   logic validX;
   logic [procPkg::opWidth-1:0] opX;
   logic [procPkg::regAddrWidth-1:0] rdX;
   logic wrEnX;
   logic memRdX;
   logic memWrX;
   logic isBranchX;
   logic isHaltX;
   logic illegalX;
   logic [procPkg::dataWidth-1:0] immX;
   logic [procPkg::dataWidth-1:0] rsValX;
   logic [procPkg::dataWidth-1:0] rtValX;
   logic [procPkg::regAddrWidth-1:0] rsIdxX;
   logic [procPkg::regAddrWidth-1:0] rtIdxX;
   logic [procPkg::imemAddrWidth-1:0] pcX;

   // execute to memory, plus the bypass paths back
   logic validM;
   logic [procPkg::dataWidth-1:0] aluM;
   logic [procPkg::dataWidth-1:0] storeM;
   logic [procPkg::regAddrWidth-1:0] rdM;
   logic wrEnM;
   logic memRdM;
   logic memWrM;
   logic haltM;
   logic illegalM;
   logic fwdMEn;
   logic [procPkg::regAddrWidth-1:0] fwdMReg;
   logic [procPkg::dataWidth-1:0] fwdMData;
   logic fwdWEn;
   logic [procPkg::regAddrWidth-1:0] fwdWReg;
   logic [procPkg::dataWidth-1:0] fwdWData;

   fetch fetchStage (
      .clk(clk), .rstN(rstN), .run(run), .halted(halted), .stall(stall),
      .redirect(redirect), .redirectPc(redirectPc), .imemWe(imemWe),
      .imemAddr(imemAddr), .imemData(imemData), .instrD(instrD), .pcD(pcD),
      .validD(validD)
   );

   // the writeback slot is the retire port
   decode decodeStage (
      .clk(clk), .rstN(rstN), .instrD(instrD), .pcD(pcD), .validD(validD),
      .redirect(redirect), .wbEn(retireValid), .wbReg(retireReg),
      .wbData(retireData), .stall(stall), .validX(validX), .opX(opX), .rdX(rdX),
      .wrEnX(wrEnX), .memRdX(memRdX), .memWrX(memWrX), .isBranchX(isBranchX),
      .isHaltX(isHaltX), .illegalX(illegalX), .immX(immX), .rsValX(rsValX),
      .rtValX(rtValX), .rsIdxX(rsIdxX), .rtIdxX(rtIdxX), .pcX(pcX)
   );

   execute executeStage (
      .clk(clk), .rstN(rstN), .validX(validX), .opX(opX), .rdX(rdX),
      .wrEnX(wrEnX), .memRdX(memRdX), .memWrX(memWrX), .isBranchX(isBranchX),
      .isHaltX(isHaltX), .illegalX(illegalX), .immX(immX), .rsValX(rsValX),
      .rtValX(rtValX), .rsIdxX(rsIdxX), .rtIdxX(rtIdxX), .pcX(pcX),
      .fwdMEn(fwdMEn), .fwdMReg(fwdMReg), .fwdMData(fwdMData), .fwdWEn(fwdWEn),
      .fwdWReg(fwdWReg), .fwdWData(fwdWData), .redirect(redirect),
      .redirectPc(redirectPc), .validM(validM), .aluM(aluM), .storeM(storeM),
      .rdM(rdM), .wrEnM(wrEnM), .memRdM(memRdM), .memWrM(memWrM), .haltM(haltM),
      .illegalM(illegalM)
   );

   memory memoryStage (
      .clk(clk), .rstN(rstN), .validM(validM), .aluM(aluM), .storeM(storeM),
      .rdM(rdM), .wrEnM(wrEnM), .memRdM(memRdM), .memWrM(memWrM), .haltM(haltM),
      .illegalM(illegalM), .fwdMEn(fwdMEn), .fwdMReg(fwdMReg),
      .fwdMData(fwdMData), .fwdWEn(fwdWEn), .fwdWReg(fwdWReg),
      .fwdWData(fwdWData), .wbEn(retireValid), .wbReg(retireReg),
      .wbData(retireData), .halted(halted), .err(err)
   );

endmodule

// File: dv/proc_asserts.sv
// concurrent checks on retirement around reset, HALT and illegal words, bound into proc
`timescale 1ns/100ps

module procAsserts (
   input logic clk,
   input logic rstN,
   input logic retireValid,
   input logic halted,
   input logic err
);

   // reset clears the W slot
   property quietAfterReset;
      @(posedge clk) !rstN |=> !retireValid;
   endproperty

   // HALT itself sits in W when halted rises, younger slots are dropped
   property quietWhileHalted;
      @(posedge clk) disable iff (!rstN) halted |-> !retireValid;
   endproperty

   // the slot behind an illegal word never retires
   property quietAfterErr;
      @(posedge clk) disable iff (!rstN) $rose(err) |=> !retireValid;
   endproperty

   resetQuiet: assert property (quietAfterReset)
      else $error("retireValid high in the cycle after reset");

   haltQuiet: assert property (quietWhileHalted)
      else $error("retireValid high while halted");

   errQuiet: assert property (quietAfterErr)
      else $error("retireValid high in the cycle after err rose");

endmodule

bind proc procAsserts procChecks (
   .clk(clk),
   .rstN(rstN),
   .retireValid(retireValid),
   .halted(halted),
   .err(err)
);

// File: dv/procTb.sv
// testbench for the five-stage core with program table, loader, retire monitor and checks
`timescale 1ns/100ps

module procTb;

   localparam int numTests = 7;
   localparam int maxWords = 16;
   localparam int maxRetire = 12;
   localparam int runLimit = 200;
   localparam int settleCycles = 10;

   typedef logic [procPkg::dataWidth-1:0] wordT;
   typedef logic [procPkg::regAddrWidth-1:0] regIdxT;
   typedef logic [procPkg::immWidth-1:0] immT;
   typedef logic [procPkg::imemAddrWidth-1:0] pcT;

   logic clk = 1'b0;
   logic rstN = 1'b0;
   logic run = 1'b0;
   logic imemWe = 1'b0;
   pcT imemAddr = '0;
   wordT imemData = '0;
   logic retireValid;
   regIdxT retireReg;
   wordT retireData;
   logic halted;
   logic err;

   // program table, one row per test
   string testName [numTests];
   wordT progWords [numTests][maxWords];
   int progLen [numTests];
   regIdxT expReg [numTests][maxRetire];
   wordT expVal [numTests][maxRetire];
   int expCount [numTests];
   logic expHalted [numTests];
   logic expErr [numTests];
   int curTest;

   // what the retire port showed during one run
   regIdxT gotReg [$];
   wordT gotVal [$];
   logic finalHalted;
   logic finalErr;

   proc u_proc (
      .clk(clk),
      .rstN(rstN),
      .run(run),
      .imemWe(imemWe),
      .imemAddr(imemAddr),
      .imemData(imemData),
      .retireValid(retireValid),
      .retireReg(retireReg),
      .retireData(retireData),
      .halted(halted),
      .err(err)
   );

   always #20 clk = ~clk;

   // assemble a register format word
   function automatic wordT regOp(input logic [procPkg::opWidth-1:0] op, input int rd,
                                  input int rs, input int rt);
      procPkg::instrT w;
      w.rFmt.opcode = op;
      w.rFmt.rd = regIdxT'(rd);
      w.rFmt.rs = regIdxT'(rs);
      w.rFmt.rt = regIdxT'(rt);
      w.rFmt.unused = 3'b000;
      return w;
   endfunction

   // assemble an immediate format word, ST keeps its data register in rd
   function automatic wordT immOp(input logic [procPkg::opWidth-1:0] op, input int rd,
                                  input int rs, input int imm);
      procPkg::instrT w;
      w.iFmt.opcode = op;
      w.iFmt.rd = regIdxT'(rd);
      w.iFmt.rs = regIdxT'(rs);
      w.iFmt.imm6 = immT'(imm);
      return w;
   endfunction

   task automatic beginTest(input int t, input string name, input logic halts,
                            input logic errs);
      curTest = t;
      testName[t] = name;
      progLen[t] = 0;
      expCount[t] = 0;
      expHalted[t] = halts;
      expErr[t] = errs;
      for (int i = 0; i < maxWords; i++) begin
         progWords[t][i] = procPkg::nopWord;
      end
   endtask

   task automatic put(input wordT w);
      progWords[curTest][progLen[curTest]] = w;
      progLen[curTest] = progLen[curTest] + 1;
   endtask

   // instruction that should show up on the retire port as r<r> = v
   task automatic putRetire(input wordT w, input int r, input int v);
      expReg[curTest][expCount[curTest]] = regIdxT'(r);
      expVal[curTest][expCount[curTest]] = wordT'(v);
      expCount[curTest] = expCount[curTest] + 1;
      put(w);
   endtask

   task automatic copyTest(input int src, input int dst, input string name);
      testName[dst] = name;
      progLen[dst] = progLen[src];
      expCount[dst] = expCount[src];
      expHalted[dst] = expHalted[src];
      expErr[dst] = expErr[src];
      for (int i = 0; i < maxWords; i++) begin
         progWords[dst][i] = progWords[src][i];
      end
      for (int i = 0; i < maxRetire; i++) begin
         expReg[dst][i] = expReg[src][i];
         expVal[dst][i] = expVal[src][i];
      end
   endtask

   // every program clears r0 first and builds its registers from it
   task automatic fillTable();
      beginTest(0, "alu_forward", 1'b1, 1'b0);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, 5), 1, 'h0005);
      putRetire(immOp(procPkg::opAddi, 2, 1, -3), 2, 'h0002);
      putRetire(regOp(procPkg::opAdd, 3, 1, 2), 3, 'h0007);
      putRetire(regOp(procPkg::opSub, 4, 3, 1), 4, 'h0002);
      putRetire(regOp(procPkg::opAnd, 5, 4, 3), 5, 'h0002);
      putRetire(regOp(procPkg::opXor, 6, 5, 3), 6, 'h0005);
      putRetire(regOp(procPkg::opSub, 7, 0, 3), 7, 'hfff9);
      putRetire(regOp(procPkg::opAdd, 1, 7, 6), 1, 'hfffe);
      put(regOp(procPkg::opHalt, 0, 0, 0));

      beginTest(1, "load_use", 1'b1, 1'b0);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, 12), 1, 'h000c);
      putRetire(immOp(procPkg::opAddi, 2, 0, -7), 2, 'hfff9);
      // mem[r1+3] = r2
      put(immOp(procPkg::opSt, 2, 1, 3));
      putRetire(immOp(procPkg::opLd, 3, 0, 15), 3, 'hfff9);
      putRetire(regOp(procPkg::opAdd, 4, 3, 1), 4, 'h0005);
      // 0xfff9 + 22 wraps back onto word 15
      putRetire(immOp(procPkg::opLd, 5, 2, 22), 5, 'hfff9);
      putRetire(immOp(procPkg::opAddi, 6, 5, 1), 6, 'hfffa);
      put(regOp(procPkg::opHalt, 0, 0, 0));

      beginTest(2, "branch_taken", 1'b1, 1'b0);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, 3), 1, 'h0003);
      put(immOp(procPkg::opBeqz, 0, 0, 2));
      put(immOp(procPkg::opAddi, 2, 0, 1));
      put(immOp(procPkg::opAddi, 3, 0, 1));
      putRetire(immOp(procPkg::opAddi, 4, 1, 1), 4, 'h0004);
      putRetire(regOp(procPkg::opSub, 5, 1, 1), 5, 'h0000);
      // target is word 9, which was already fetched and flushed
      put(immOp(procPkg::opBeqz, 0, 5, 1));
      put(immOp(procPkg::opAddi, 6, 0, 7));
      putRetire(immOp(procPkg::opAddi, 7, 4, -1), 7, 'h0003);
      put(regOp(procPkg::opHalt, 0, 0, 0));

      beginTest(3, "branch_not_taken", 1'b1, 1'b0);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, -1), 1, 'hffff);
      put(immOp(procPkg::opBeqz, 0, 1, 2));
      putRetire(immOp(procPkg::opAddi, 2, 1, 2), 2, 'h0001);
      putRetire(immOp(procPkg::opAddi, 3, 2, 2), 3, 'h0003);
      put(regOp(procPkg::opHalt, 0, 0, 0));

      beginTest(4, "halt_stops", 1'b1, 1'b0);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, 9), 1, 'h0009);
      putRetire(immOp(procPkg::opAddi, 2, 1, -1), 2, 'h0008);
      put(regOp(procPkg::opHalt, 0, 0, 0));

      beginTest(5, "illegal_op", 1'b0, 1'b1);
      putRetire(regOp(procPkg::opXor, 0, 0, 0), 0, 'h0000);
      putRetire(immOp(procPkg::opAddi, 1, 0, 4), 1, 'h0004);
      putRetire(regOp(procPkg::opAdd, 2, 1, 1), 2, 'h0008);
      // opcode 9 is unassigned
      put(regOp(4'h9, 3, 1, 1));
      put(immOp(procPkg::opAddi, 4, 0, 1));
      put(regOp(procPkg::opHalt, 0, 0, 0));

      copyTest(0, 6, "alu_forward_rerun");
   endtask

   task automatic resetCore();
      @(posedge clk);
      rstN <= 1'b0;
      run <= 1'b0;
      imemWe <= 1'b0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
   endtask

   // table words first, random words behind the program
   task automatic loadProgram(input int t);
      for (int a = 0; a < procPkg::imemDepth; a++) begin
         @(posedge clk);
         imemWe <= 1'b1;
         imemAddr <= pcT'(a);
         if (a < progLen[t]) begin
            imemData <= progWords[t][a];
         end else begin
            imemData <= wordT'($urandom);
         end
      end
      @(posedge clk);
      imemWe <= 1'b0;
   endtask

   task automatic runProgram(output logic timedOut);
      int cycles;
      logic done;
      cycles = 0;
      done = 1'b0;
      gotReg.delete();
      gotVal.delete();
      @(posedge clk);
      run <= 1'b1;
      while (!done && cycles < runLimit) begin
         @(negedge clk);
         cycles++;
         if (retireValid) begin
            gotReg.push_back(retireReg);
            gotVal.push_back(retireData);
         end
         done = halted || err;
      end
      timedOut = !done;
      // keep watching so a late retirement or a dropped flag is caught
      if (done) begin
         repeat (settleCycles) begin
            @(negedge clk);
            if (retireValid) begin
               gotReg.push_back(retireReg);
               gotVal.push_back(retireData);
            end
         end
      end
      finalHalted = halted;
      finalErr = err;
   endtask

   task automatic checkResults(input int t, output int errs);
      int n;
      errs = 0;
      assert (gotReg.size() == expCount[t]) else begin
         $display("Error %s retire count expected %0d actual %0d",
                  testName[t], expCount[t], gotReg.size());
         errs++;
      end
      n = (gotReg.size() < expCount[t]) ? gotReg.size() : expCount[t];
      for (int i = 0; i < n; i++) begin
         assert (gotReg[i] == expReg[t][i] && gotVal[i] == expVal[t][i]) else begin
            $display("Error %s retire %0d expected r%0d=%h actual r%0d=%h", testName[t], i,
                     expReg[t][i], expVal[t][i], gotReg[i], gotVal[i]);
            errs++;
         end
      end
      assert (finalHalted == expHalted[t]) else begin
         $display("Error %s halted expected %b actual %b",
                  testName[t], expHalted[t], finalHalted);
         errs++;
      end
      assert (finalErr == expErr[t]) else begin
         $display("Error %s err expected %b actual %b", testName[t], expErr[t], finalErr);
         errs++;
      end
   endtask

   initial begin
      int failedTests;
      int testErrs;
      logic timedOut;
      failedTests = 0;
      void'($urandom(30045));
      fillTable();
      for (int t = 0; t < numTests; t++) begin
         resetCore();
         loadProgram(t);
         runProgram(timedOut);
         if (timedOut) begin
            $display("Timeout: test %s neither halted nor raised err within %0d cycles",
                     testName[t], runLimit);
            testErrs = 1;
         end else begin
            checkResults(t, testErrs);
         end
         if (testErrs == 0) begin
            $display("test %s passed with %0d retirements", testName[t], gotReg.size());
         end else begin
            $display("test %s failed with %0d errors", testName[t], testErrs);
            failedTests++;
         end
      end
      $display("tests run %0d, passed %0d, failed %0d",
               numTests, numTests - failedTests, failedTests);
      if (failedTests == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

// File: list.f
rtl/procPkg.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/memory.sv
rtl/proc.sv
dv/proc_asserts.sv
dv/procTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module procTb -o procSim -f list.f
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
   echo "Verilator build failed with status $buildStatus"
   exit 1
fi

simOutput=$(./obj_dir/procSim 2>&1)
simStatus=$?
echo "$simOutput"
if [ "$simStatus" -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi

if echo "$simOutput" | grep -q "^PASS: all tests$"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
